// ==== logic/pcie_tlp_pkg.sv ====
// ====================
// PCIe TLP definitions used by the read bridge
// Headers are flat structs and not the wire layout of a real TLP
// Only the format codes for MRd32, MRd64, CplD and Cpl are modeled
// ====================

package pcie_tlp_pkg;

    // ====================
    // Field widths
    // ====================

    // Eight request tags are enough for the outstanding read window
    localparam int TAG_W = 3;

    typedef logic [TAG_W-1:0] tlp_tag_t;

    // Format and type share one byte as in DW0 of the TLP header
    typedef logic [7:0] tlp_fmttype_t;

    // Payload length in dwords as in the length field of DW0
    typedef logic [9:0] dw_len_t;

    // Bytes still outstanding for the whole read, carried by each completion
    typedef logic [11:0] byte_count_t;

    // ====================
    // Format codes
    // ====================

    // Memory read with a 3 dword header for addresses below 4 GB
    localparam tlp_fmttype_t FMT_MRD32 = 8'h00;
    // Memory read with a 4 dword header, only legal above 4 GB
    localparam tlp_fmttype_t FMT_MRD64 = 8'h20;
    // Completion carrying data
    localparam tlp_fmttype_t FMT_CPLD = 8'h4a;
    // Completion without data
    localparam tlp_fmttype_t FMT_CPL = 8'h0a;

    // ====================
    // Headers and beats
    // ====================

    // Memory read request header, sent as a single beat
    typedef struct packed {
        tlp_fmttype_t fmttype;
        logic [63:0]  addr;
        dw_len_t      length;
        tlp_tag_t     tag;
        logic [3:0]   first_be;
        logic [3:0]   last_be;
    } rd_req_tlp_t;

    // Completion header fields that the decoder looks at
    typedef struct packed {
        tlp_fmttype_t fmttype;
        tlp_tag_t     tag;
        dw_len_t      length;
        byte_count_t  byte_count;
    } cpl_hdr_t;

    // One beat of the completion stream
    // The header is only meaningful when sop is set
    typedef struct packed {
        logic        sop;
        logic        eop;
        cpl_hdr_t    hdr;
        logic [63:0] payload;
    } cpl_beat_t;

endpackage

// ==== logic/afu_rd_pkg.sv ====
// ====================
// AFU side read request and response types
// A line is 64 bits and a request spans 1 to 4 lines
// N_TAGS must match the range of the PCIe tag type
// ====================

package afu_rd_pkg;

    // Reads that may be outstanding on the link at once
    localparam int N_TAGS = 8;

    // A line is two dwords, or eight bytes
    localparam int LINE_DW_LOG2 = 1;
    localparam int LINE_BYTES_LOG2 = 3;

    typedef logic [7:0] afu_tag_t;

    // Holds 1 to 4, so zero is never a legal count
    typedef logic [2:0] line_count_t;

    typedef logic [1:0] line_idx_t;

    typedef struct packed {
        logic [63:0] addr;
        line_count_t line_count;
        afu_tag_t    tag;
    } afu_rd_req_t;

    typedef struct packed {
        afu_tag_t    tag;
        line_idx_t   line_idx;
        logic        last;
        logic [63:0] payload;
    } afu_rd_rsp_t;

    // What the completion side needs to know about a request
    typedef struct packed {
        afu_tag_t    afu_tag;
        line_count_t line_count;
    } rd_meta_t;

    // Completion decoder state, active while inside a CplD packet
    typedef enum logic {
        CPL_IDLE,
        CPL_ACTIVE
    } cpl_state_t;

endpackage

// ==== logic/rd_req_fifo.sv ====
// ====================
// Two entry request FIFO
// enq must only be raised while not_full is high
// deq must only be raised while not_empty is high
// ====================

module rd_req_fifo
(
    input  logic                     clk,
    input  logic                     reset_n,

    input  logic                     enq,
    input  afu_rd_pkg::afu_rd_req_t  enq_req,
    output logic                     not_full,

    input  logic                     deq,
    output afu_rd_pkg::afu_rd_req_t  first_req,
    output logic                     first_is_addr64,
    output logic                     not_empty
);

    // Storage for the two slots
    afu_rd_pkg::afu_rd_req_t mem_req [2];
    logic [1:0]              mem_addr64;

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    assign not_full = (count != 2'd2);
    assign not_empty = (count != 2'd0);

    // Head of the queue is always presented
    assign first_req = mem_req[rd_ptr];
    assign first_is_addr64 = mem_addr64[rd_ptr];

    // MRd64 is illegal for addresses below 4 GB, so the wide OR of the upper
    // half is done here on the way in and stored next to the request
    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem_req[wr_ptr] <= enq_req;
            mem_addr64[wr_ptr] <= |enq_req.addr[63:32];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (enq)
                wr_ptr <= !wr_ptr;
            if (deq)
                rd_ptr <= !rd_ptr;

            // Simultaneous enq and deq leave the count unchanged
            case ({enq, deq})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== logic/rd_tag_pool.sv ====
// ====================
// PCIe read tag allocator with per tag metadata
// The lowest free tag is always offered, alloc takes it
// free must name a tag that is currently busy
// ====================

module rd_tag_pool
(
    input  logic                    clk,
    input  logic                    reset_n,

    // Allocation side, driven by the request encoder
    input  logic                    alloc,
    input  afu_rd_pkg::rd_meta_t    alloc_meta,
    output logic                    alloc_ready,
    output pcie_tlp_pkg::tlp_tag_t  alloc_tag,

    // Release side, driven by the completion decoder
    input  logic                    free,
    input  pcie_tlp_pkg::tlp_tag_t  free_tag,

    // Asynchronous metadata read for completions
    input  pcie_tlp_pkg::tlp_tag_t  lookup_tag,
    output afu_rd_pkg::rd_meta_t    lookup_meta
);

    // One bit per tag, set while the read is on the link
    logic [afu_rd_pkg::N_TAGS-1:0] busy;

    // Metadata indexed by tag, written at allocation time
    afu_rd_pkg::rd_meta_t meta [afu_rd_pkg::N_TAGS];

    // ====================
    // Free tag search
    // ====================

    // Walk from the top down so the lowest free index wins
    always_comb
    begin
        alloc_ready = 1'b0;
        alloc_tag = '0;
        for (int i = afu_rd_pkg::N_TAGS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                alloc_ready = 1'b1;
                alloc_tag = pcie_tlp_pkg::tlp_tag_t'(i);
            end
        end
    end

    // ====================
    // Busy bitmap
    // ====================

    // A tag being freed is busy and a tag being allocated is free,
    // so the two updates never touch the same bit
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            busy <= '0;
        end
        else
        begin
            if (free)
                busy[free_tag] <= 1'b0;
            if (alloc)
                busy[alloc_tag] <= 1'b1;
        end
    end

    // Metadata entry is written in the same cycle the tag is taken
    always_ff @(posedge clk)
    begin
        if (alloc)
            meta[alloc_tag] <= alloc_meta;
    end

    // Read is combinational so the decoder sees it in the sop cycle
    assign lookup_meta = meta[lookup_tag];

endmodule

// ==== logic/rd_req_encoder.sv ====
// ====================
// Turns queued AFU reads into memory read TLP headers
// Output is registered, one header per beat
// A request only leaves when a tag is available
// ====================

module rd_req_encoder
(
    input  logic                         clk,
    input  logic                         reset_n,

    // Head of the request FIFO
    input  logic                         not_empty,
    input  afu_rd_pkg::afu_rd_req_t      first_req,
    input  logic                         first_is_addr64,
    output logic                         deq,

    // Tag pool
    input  logic                         alloc_ready,
    input  pcie_tlp_pkg::tlp_tag_t       alloc_tag,
    output logic                         alloc,
    output afu_rd_pkg::rd_meta_t         alloc_meta,

    // TLP output stream
    output logic                         tx_valid,
    input  logic                         tx_ready,
    output pcie_tlp_pkg::rd_req_tlp_t    tx_tlp
);

    pcie_tlp_pkg::rd_req_tlp_t hdr;
    logic                      out_free;

    // The output register can take a new header when empty or draining
    assign out_free = tx_ready || !tx_valid;

    // Popping the FIFO and taking a tag are one and the same event
    assign deq = not_empty && alloc_ready && out_free;
    assign alloc = deq;

    // Remember where the completion must go and how many lines to expect
    assign alloc_meta.afu_tag = first_req.tag;
    assign alloc_meta.line_count = first_req.line_count;

    always_comb
    begin
        hdr = '0;
        if (first_is_addr64)
        begin
            hdr.fmttype = pcie_tlp_pkg::FMT_MRD64;
            hdr.addr = first_req.addr;
        end
        else
        begin
            // Upper half is known to be zero, keep only the low dword
            hdr.fmttype = pcie_tlp_pkg::FMT_MRD32;
            hdr.addr = {32'b0, first_req.addr[31:0]};
        end
        hdr.length = pcie_tlp_pkg::dw_len_t'(first_req.line_count) << afu_rd_pkg::LINE_DW_LOG2;
        hdr.tag = alloc_tag;
        // Whole dwords are always read
        hdr.first_be = 4'b1111;
        hdr.last_be = 4'b1111;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            tx_valid <= 1'b0;
        else if (out_free)
            tx_valid <= deq;
    end

    always_ff @(posedge clk)
    begin
        if (deq)
            tx_tlp <= hdr;
    end

endmodule

// ==== logic/rd_cpl_decoder.sv ====
// ====================
// Completion decoder for read TLPs
// Every beat carries exactly one 64 bit line
// Anything but CplD is accepted and dropped
// Packets of different tags may interleave, beats of one packet may not
// ====================

module rd_cpl_decoder
(
    input  logic                        clk,
    input  logic                        reset_n,

    // Completion stream from the host
    input  logic                        cpl_valid,
    output logic                        cpl_ready,
    input  pcie_tlp_pkg::cpl_beat_t     cpl,

    // Tag pool lookup and release
    output pcie_tlp_pkg::tlp_tag_t      lookup_tag,
    input  afu_rd_pkg::rd_meta_t        lookup_meta,
    output logic                        free,
    output pcie_tlp_pkg::tlp_tag_t      free_tag,

    // Response stream to the AFU
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output afu_rd_pkg::afu_rd_rsp_t     rsp
);

    afu_rd_pkg::cpl_state_t state;

    // Values captured on sop and reused by the following beats
    pcie_tlp_pkg::tlp_tag_t  reg_tlp_tag;
    afu_rd_pkg::afu_tag_t    reg_afu_tag;
    afu_rd_pkg::line_idx_t   reg_line_idx;
    logic                    reg_last_pkt;

    // Per beat view, valid both on sop and on continuation beats
    logic                    beat_active;
    pcie_tlp_pkg::tlp_tag_t  cur_tlp_tag;
    afu_rd_pkg::afu_tag_t    cur_afu_tag;
    afu_rd_pkg::line_idx_t   cur_line_idx;
    logic                    cur_last_pkt;
    afu_rd_pkg::line_count_t remaining_lines;
    logic                    cpl_xfer;

    // Tag of the response being held, released with the last line
    pcie_tlp_pkg::tlp_tag_t  rsp_tlp_tag;

    // A stalled response blocks the completion stream
    assign cpl_ready = !rsp_valid || rsp_ready;
    assign cpl_xfer = cpl_valid && cpl_ready;

    assign lookup_tag = cpl.hdr.tag;

    // byte_count counts what is left of the whole read, including this packet
    assign remaining_lines = afu_rd_pkg::line_count_t'(
        cpl.hdr.byte_count >> afu_rd_pkg::LINE_BYTES_LOG2);

    always_comb
    begin
        if (cpl.sop)
        begin
            beat_active = (cpl.hdr.fmttype == pcie_tlp_pkg::FMT_CPLD);
            cur_tlp_tag = cpl.hdr.tag;
            cur_afu_tag = lookup_meta.afu_tag;
            // Lines already delivered by earlier packets give the start index
            cur_line_idx = afu_rd_pkg::line_idx_t'(lookup_meta.line_count - remaining_lines);
            // Final packet when what remains is exactly this packet
            cur_last_pkt = (cpl.hdr.byte_count[11:2] == cpl.hdr.length);
        end
        else
        begin
            beat_active = (state == afu_rd_pkg::CPL_ACTIVE);
            cur_tlp_tag = reg_tlp_tag;
            cur_afu_tag = reg_afu_tag;
            cur_line_idx = reg_line_idx + 2'd1;
            cur_last_pkt = reg_last_pkt;
        end
    end

    // ====================
    // Packet tracking
    // ====================

    // Single beat packets return straight to idle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= afu_rd_pkg::CPL_IDLE;
        else if (cpl_xfer)
            state <= (beat_active && !cpl.eop) ? afu_rd_pkg::CPL_ACTIVE
                                               : afu_rd_pkg::CPL_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (cpl_xfer)
        begin
            reg_tlp_tag <= cur_tlp_tag;
            reg_afu_tag <= cur_afu_tag;
            reg_line_idx <= cur_line_idx;
            reg_last_pkt <= cur_last_pkt;
        end
    end

    // ====================
    // Response register
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            rsp_valid <= 1'b0;
        else if (cpl_ready)
            rsp_valid <= cpl_xfer && beat_active;
    end

    always_ff @(posedge clk)
    begin
        if (cpl_xfer && beat_active)
        begin
            rsp.tag <= cur_afu_tag;
            rsp.line_idx <= cur_line_idx;
            // Only the eop beat of the final packet closes the request
            rsp.last <= cur_last_pkt && cpl.eop;
            rsp.payload <= cpl.payload;
            rsp_tlp_tag <= cur_tlp_tag;
        end
    end

    // Tag goes back to the pool once the AFU has taken the last line
    assign free = rsp_valid && rsp_ready && rsp.last;
    assign free_tag = rsp_tlp_tag;

endmodule

// ==== logic/rd_tlp_gen.sv ====
// ====================
// Read side of the host channel bridge
// AFU reads in, memory read TLPs out, completions back in as line responses
// Up to eight reads may be outstanding on the link
// ====================

module rd_tlp_gen
(
    input  logic                         clk,
    input  logic                         reset_n,

    // AFU read requests
    input  logic                         req_valid,
    output logic                         req_ready,
    input  afu_rd_pkg::afu_rd_req_t      req,

    // Memory read TLPs toward the host
    output logic                         tx_valid,
    input  logic                         tx_ready,
    output pcie_tlp_pkg::rd_req_tlp_t    tx_tlp,

    // Completions from the host
    input  logic                         cpl_valid,
    output logic                         cpl_ready,
    input  pcie_tlp_pkg::cpl_beat_t      cpl,

    // Line responses to the AFU
    output logic                         rsp_valid,
    input  logic                         rsp_ready,
    output afu_rd_pkg::afu_rd_rsp_t      rsp
);

    // FIFO head toward the encoder
    afu_rd_pkg::afu_rd_req_t  first_req;
    logic                     first_is_addr64;
    logic                     fifo_not_empty;
    logic                     fifo_deq;

    // Tag pool connections
    logic                     alloc;
    logic                     alloc_ready;
    pcie_tlp_pkg::tlp_tag_t   alloc_tag;
    afu_rd_pkg::rd_meta_t     alloc_meta;
    logic                     free;
    pcie_tlp_pkg::tlp_tag_t   free_tag;
    pcie_tlp_pkg::tlp_tag_t   lookup_tag;
    afu_rd_pkg::rd_meta_t     lookup_meta;

    rd_req_fifo req_fifo
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .enq             (req_valid && req_ready),
        .enq_req         (req),
        .not_full        (req_ready),
        .deq             (fifo_deq),
        .first_req       (first_req),
        .first_is_addr64 (first_is_addr64),
        .not_empty       (fifo_not_empty)
    );

    rd_tag_pool tag_pool
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .alloc       (alloc),
        .alloc_meta  (alloc_meta),
        .alloc_ready (alloc_ready),
        .alloc_tag   (alloc_tag),
        .free        (free),
        .free_tag    (free_tag),
        .lookup_tag  (lookup_tag),
        .lookup_meta (lookup_meta)
    );

    rd_req_encoder req_encoder
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .not_empty       (fifo_not_empty),
        .first_req       (first_req),
        .first_is_addr64 (first_is_addr64),
        .deq             (fifo_deq),
        .alloc_ready     (alloc_ready),
        .alloc_tag       (alloc_tag),
        .alloc           (alloc),
        .alloc_meta      (alloc_meta),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready),
        .tx_tlp          (tx_tlp)
    );

    rd_cpl_decoder cpl_decoder
    (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpl_valid   (cpl_valid),
        .cpl_ready   (cpl_ready),
        .cpl         (cpl),
        .lookup_tag  (lookup_tag),
        .lookup_meta (lookup_meta),
        .free        (free),
        .free_tag    (free_tag),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp)
    );

endmodule

// ==== verif/rd_tlp_gen_properties.sv ====
// ====================
// Handshake assertions for the read bridge top
// Bound into every rd_tlp_gen instance
// ====================

module rd_tlp_gen_properties
(
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       tx_valid,
    input  logic                       tx_ready,
    input  pcie_tlp_pkg::rd_req_tlp_t  tx_tlp,
    input  logic                       rsp_valid,
    input  logic                       rsp_ready,
    input  afu_rd_pkg::afu_rd_rsp_t    rsp
);

    // A TLP on offer stays on offer and unchanged until taken
    tx_held: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_tlp))
        else $error("TLP header changed while the TLP stream was stalled");

    // Same rule on the response side
    rsp_held: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("Response changed while the response stream was stalled");

    // Both output streams come out of reset idle
    idle_after_reset: assert property (@(posedge clk)
        !reset_n |=> !tx_valid && !rsp_valid)
        else $error("Output valid was high right after reset");

endmodule

bind rd_tlp_gen rd_tlp_gen_properties handshake_props
(
    .clk       (clk),
    .reset_n   (reset_n),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .tx_tlp    (tx_tlp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

// ==== verif/rd_tlp_gen_tb.sv ====
// ====================
// Testbench for the read bridge top with a host completion model
// Stimulus is random from a fixed seed and covers 300 requests
// Completion packets go out whole and packets of different reads interleave
// ====================

module rd_tlp_gen_tb;

    localparam int NUM_REQ = 300;
    localparam int CLK_PERIOD = 40;
    localparam int DRAIN_CYCLES = 40;
    // Message request routed to the root complex and never a completion
    localparam pcie_tlp_pkg::tlp_fmttype_t MSG_CODE = 8'h30;

    // What the DUT must do with one completion beat
    typedef struct packed {
        logic                    is_data;
        pcie_tlp_pkg::tlp_tag_t  tlp_tag;
        afu_rd_pkg::afu_rd_rsp_t rsp;
    } exp_beat_t;

    // Host side record of one read on the link for each PCIe tag
    typedef struct packed {
        logic                    busy;
        afu_rd_pkg::afu_rd_req_t req;
        afu_rd_pkg::line_count_t lines_sent;
    } host_entry_t;

    logic                      clk;
    logic                      reset_n;
    logic                      req_valid;
    logic                      req_ready;
    afu_rd_pkg::afu_rd_req_t   req;
    logic                      tx_valid;
    logic                      tx_ready;
    pcie_tlp_pkg::rd_req_tlp_t tx_tlp;
    logic                      cpl_valid;
    logic                      cpl_ready;
    pcie_tlp_pkg::cpl_beat_t   cpl;
    logic                      rsp_valid;
    logic                      rsp_ready;
    afu_rd_pkg::afu_rd_rsp_t   rsp;

    // Requests accepted by the DUT and not yet seen as TLPs
    afu_rd_pkg::afu_rd_req_t   req_q [$];
    // Beats waiting to go out and the expected effect of each
    pcie_tlp_pkg::cpl_beat_t   beat_q [$];
    exp_beat_t                 beat_exp_q [$];
    // Lines accepted by the DUT and owed to the AFU in order
    exp_beat_t                 rsp_exp_q [$];
    host_entry_t               host_tab [afu_rd_pkg::N_TAGS];

    int errors;
    int issued;
    int completed;
    int outstanding;

    rd_tlp_gen UUT
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .tx_tlp    (tx_tlp),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Builds a line aligned request whose address is below 4 GB half of the time
    function automatic afu_rd_pkg::afu_rd_req_t make_request(input int num);
        afu_rd_pkg::afu_rd_req_t r;
        r.addr[63:32] = ($urandom % 2 == 0) ? 32'h0 : ($urandom | 32'h0000_0100);
        r.addr[31:0] = $urandom & 32'hffff_fff8;
        r.line_count = afu_rd_pkg::line_count_t'(1 + $urandom % 4);
        r.tag = afu_rd_pkg::afu_tag_t'(num);
        return r;
    endfunction

    // ====================
    // Host completion model
    // ====================

    task automatic build_packet();
        int                      cand [$];
        int                      pick;
        int                      left;
        int                      n;
        int                      idx;
        logic [63:0]             line_addr;
        pcie_tlp_pkg::cpl_beat_t beat;
        exp_beat_t               e;
        for (int t = 0; t < afu_rd_pkg::N_TAGS; t++)
        begin
            if (host_tab[t].busy && host_tab[t].lines_sent != host_tab[t].req.line_count)
                cand.push_back(t);
        end
        if ($urandom % 10 == 0)
        begin
            // Dataless completion or message of one or two beats that owes no response
            n = 1 + int'($urandom % 2);
            for (int i = 0; i < n; i++)
            begin
                beat = '0;
                beat.sop = (i == 0);
                beat.eop = (i == n - 1);
                beat.hdr.fmttype = ($urandom % 2 == 0) ? pcie_tlp_pkg::FMT_CPL : MSG_CODE;
                beat.hdr.tag = pcie_tlp_pkg::tlp_tag_t'($urandom);
                beat.hdr.length = pcie_tlp_pkg::dw_len_t'(2 * n);
                beat.hdr.byte_count = pcie_tlp_pkg::byte_count_t'(8 * n);
                beat.payload = {$urandom, $urandom};
                e = '0;
                beat_q.push_back(beat);
                beat_exp_q.push_back(e);
            end
        end
        else if (cand.size() != 0)
        begin
            pick = cand[$urandom % cand.size()];
            left = int'(host_tab[pick].req.line_count) - int'(host_tab[pick].lines_sent);
            n = 1 + int'($urandom % left);
            for (int i = 0; i < n; i++)
            begin
                idx = int'(host_tab[pick].lines_sent) + i;
                line_addr = host_tab[pick].req.addr + 64'(8 * idx);
                beat = '0;
                beat.sop = (i == 0);
                beat.eop = (i == n - 1);
                if (i == 0)
                begin
                    // byte_count covers this packet and every packet after it
                    beat.hdr.fmttype = pcie_tlp_pkg::FMT_CPLD;
                    beat.hdr.tag = pcie_tlp_pkg::tlp_tag_t'(pick);
                    beat.hdr.length = pcie_tlp_pkg::dw_len_t'(2 * n);
                    beat.hdr.byte_count = pcie_tlp_pkg::byte_count_t'(8 * left);
                end
                beat.payload = {~line_addr[31:0], line_addr[31:0]};
                e.is_data = 1'b1;
                e.tlp_tag = pcie_tlp_pkg::tlp_tag_t'(pick);
                e.rsp.tag = host_tab[pick].req.tag;
                e.rsp.line_idx = afu_rd_pkg::line_idx_t'(idx);
                e.rsp.last = (idx == int'(host_tab[pick].req.line_count) - 1);
                e.rsp.payload = beat.payload;
                beat_q.push_back(beat);
                beat_exp_q.push_back(e);
            end
            host_tab[pick].lines_sent =
                afu_rd_pkg::line_count_t'(int'(host_tab[pick].lines_sent) + n);
        end
    endtask

    // ====================
    // Per cycle checks and drive
    // ====================

    task automatic check_tlp();
        afu_rd_pkg::afu_rd_req_t r;
        logic                    wide;
        if (req_q.size() == 0)
        begin
            errors++;
            $display("Error at %0t: a TLP was sent with no request pending", $time);
            return;
        end
        r = req_q.pop_front();
        wide = (r.addr[63:32] != 32'h0);
        check_value(64'(tx_tlp.fmttype),
                    64'(wide ? pcie_tlp_pkg::FMT_MRD64 : pcie_tlp_pkg::FMT_MRD32), "TLP format");
        check_value(tx_tlp.addr, wide ? r.addr : {32'h0, r.addr[31:0]}, "TLP address");
        check_value(64'(tx_tlp.length), 64'(2 * int'(r.line_count)), "TLP length");
        check_value(64'({tx_tlp.first_be, tx_tlp.last_be}), 64'hff, "TLP byte enables");
        if (host_tab[tx_tlp.tag].busy)
        begin
            errors++;
            $display("Error at %0t: TLP tag %0d is still outstanding", $time, tx_tlp.tag);
        end
        host_tab[tx_tlp.tag].busy = 1'b1;
        host_tab[tx_tlp.tag].req = r;
        host_tab[tx_tlp.tag].lines_sent = '0;
        outstanding++;
        if (outstanding > afu_rd_pkg::N_TAGS)
        begin
            errors++;
            $display("Error at %0t: more than %0d reads outstanding", $time, afu_rd_pkg::N_TAGS);
        end
    endtask

    task automatic check_response();
        exp_beat_t e;
        if (rsp_exp_q.size() == 0)
        begin
            errors++;
            $display("Error at %0t: a response arrived with no line owed", $time);
            return;
        end
        e = rsp_exp_q.pop_front();
        check_value(64'(rsp.tag), 64'(e.rsp.tag), "response AFU tag");
        check_value(64'(rsp.line_idx), 64'(e.rsp.line_idx), "response line index");
        check_value(64'(rsp.last), 64'(e.rsp.last), "response last flag");
        check_value(rsp.payload, e.rsp.payload, "response payload");
        // The read is closed once its final line is delivered
        if (e.rsp.last)
        begin
            host_tab[e.tlp_tag].busy = 1'b0;
            outstanding--;
            completed++;
        end
    endtask

    task automatic drive_inputs();
        if (!req_valid || req_ready)
        begin
            if (issued < NUM_REQ && $urandom % 4 != 0)
            begin
                req <= make_request(issued);
                req_valid <= 1'b1;
                issued++;
            end
            else
                req_valid <= 1'b0;
        end
        tx_ready <= ($urandom % 4 != 0);
        rsp_ready <= ($urandom % 4 != 0);
        // A beat on offer stays put until it is taken
        if (!cpl_valid || cpl_ready)
        begin
            if (beat_q.size() == 0)
                build_packet();
            if (beat_q.size() != 0 && $urandom % 8 != 0)
            begin
                cpl <= beat_q[0];
                cpl_valid <= 1'b1;
            end
            else
                cpl_valid <= 1'b0;
        end
    endtask

    task automatic run_cycle();
        exp_beat_t e;
        if (rsp_valid && rsp_ready)
            check_response();
        if (tx_valid && tx_ready)
            check_tlp();
        if (req_valid && req_ready)
            req_q.push_back(req);
        if (cpl_valid && cpl_ready)
        begin
            beat_q.delete(0);
            e = beat_exp_q.pop_front();
            if (e.is_data)
                rsp_exp_q.push_back(e);
        end
        drive_inputs();
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        void'($urandom(32'h9448_62ab));
        clk = 1'b0;
        reset_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        tx_ready = 1'b0;
        cpl_valid = 1'b0;
        cpl = '0;
        rsp_ready = 1'b0;
        errors = 0;
        issued = 0;
        completed = 0;
        outstanding = 0;
        for (int t = 0; t < afu_rd_pkg::N_TAGS; t++)
            host_tab[t] = '0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        while (completed < NUM_REQ)
        begin
            @(posedge clk);
            run_cycle();
        end
        // Keep junk packets flowing for a while to catch stray responses
        repeat (DRAIN_CYCLES)
        begin
            @(posedge clk);
            run_cycle();
        end
        // Every read is answered, so both output streams must now be idle
        if (tx_valid || rsp_valid)
        begin
            errors++;
            $display("Error at %0t: the DUT still offered output after the last request",
                     $time);
        end
        $display("Closing report: %0d errors, %0d of %0d requests completed",
                 errors, completed, NUM_REQ);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Roughly 60 cycles per request is far beyond the worst case
    initial
    begin
        #(NUM_REQ * 60 * CLK_PERIOD);
        $display("Timeout: the run did not finish all %0d requests in time", NUM_REQ);
        $display("Closing report: %0d errors, %0d of %0d requests completed",
                 errors, completed, NUM_REQ);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== project.f ====
logic/pcie_tlp_pkg.sv
logic/afu_rd_pkg.sv
logic/rd_req_fifo.sv
logic/rd_tag_pool.sv
logic/rd_req_encoder.sv
logic/rd_cpl_decoder.sv
logic/rd_tlp_gen.sv
verif/rd_tlp_gen_properties.sv
verif/rd_tlp_gen_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the read bridge testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module rd_tlp_gen_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vrd_tlp_gen_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
